/* Makefile */
TOP = acc_proc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f acc_proc.f -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir

/* acc_proc.f */
source/acc_proc_pkg.sv
source/alu.sv
source/data_cache.sv
source/fetch_stage.sv
source/execute_stage.sv
source/acc_proc.sv
tb/acc_proc_checker.sv
tb/acc_proc_tb.sv

/* source/acc_proc.sv */
`timescale 1ns/100ps

module acc_proc (
	input  logic                 g_clk,
	input  logic                 arst_n,
	input  logic                 run,
	input  logic                 prog_we,
	input  acc_proc_pkg::addr_t  prog_addr,
	input  acc_proc_pkg::instr_t prog_data,
	input  logic                 in_dev_hs,
	input  acc_proc_pkg::word_t  input_bus,
	input  logic                 out_dev_hs,
	input  logic                 out_dev_ack,
	output logic                 in_dev_ack,
	output logic                 out_dev_req,
	output acc_proc_pkg::word_t  output_bus,
	output logic                 halted
);
	import acc_proc_pkg::*;

	// Fetch to execute
	instr_t  instr;
	logic    instr_valid;
	logic    ex_busy;
	logic    redirect;
	addr_t   redirect_addr;

	// Execute to ALU
	alu_op_t alu_op;
	word_t   acc;
	word_t   alu_operand;
	logic    carry_in;
	word_t   alu_result;
	flags_t  alu_flags;

	// Execute to cache
	logic    mem_req;
	logic    mem_we;
	addr_t   mem_addr;
	word_t   mem_wdata;
	logic    mem_done;
	word_t   mem_rdata;

	fetch_stage u_fetch (
		.g_clk, .arst_n, .run,
		.prog_we, .prog_addr, .prog_data,
		.ex_busy, .redirect, .redirect_addr, .halted,
		.instr, .instr_valid
	);

	execute_stage u_execute (
		.g_clk, .arst_n, .run,
		.instr, .instr_valid,
		.alu_result, .alu_flags,
		.mem_done, .mem_rdata,
		.in_dev_hs, .input_bus, .out_dev_hs, .out_dev_ack,
		.ex_busy, .redirect, .redirect_addr,
		.alu_op, .acc, .alu_operand, .carry_in,
		.mem_req, .mem_we, .mem_addr, .mem_wdata,
		.in_dev_ack, .out_dev_req, .output_bus, .halted
	);

	// Accumulator is always the first operand
	alu u_alu (
		.op       (alu_op),
		.a        (acc),
		.b        (alu_operand),
		.carry_in (carry_in),
		.result   (alu_result),
		.flags    (alu_flags)
	);

	data_cache u_cache (
		.g_clk  (g_clk),
		.arst_n (arst_n),
		.req    (mem_req),
		.we     (mem_we),
		.addr   (mem_addr),
		.wdata  (mem_wdata),
		.done   (mem_done),
		.rdata  (mem_rdata)
	);

endmodule

/* source/acc_proc_pkg.sv */
package acc_proc_pkg;

	////////////////////
	// Data and address widths
	////////////////////

	// One data byte
	typedef logic [7:0] word_t;
	// Data RAM and instruction memory address
	typedef logic [7:0] addr_t;
	// Opcode in the upper byte, operand in the lower byte
	typedef logic [15:0] instr_t;
	// Condition codes, ordered C V Z
	typedef logic [2:0] flags_t;
	// ALU function select
	typedef logic [2:0] alu_op_t;

	// Bit positions inside flags_t
	localparam int FLAG_C = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_Z = 0;

	// Memory sizes
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int CACHE_LINES = 4;
	localparam int CACHE_IDX_W = $clog2(CACHE_LINES);

	////////////////////
	// Opcodes
	////////////////////

	localparam logic [7:0] OP_NOP  = 8'h00;
	localparam logic [7:0] OP_LDI  = 8'h01;
	localparam logic [7:0] OP_LDM  = 8'h02;
	localparam logic [7:0] OP_STM  = 8'h03;
	// Second operand comes from mem[operand]
	localparam logic [7:0] OP_ADD  = 8'h10;
	localparam logic [7:0] OP_ADC  = 8'h11;
	localparam logic [7:0] OP_SUB  = 8'h12;
	localparam logic [7:0] OP_AND  = 8'h13;
	localparam logic [7:0] OP_OR   = 8'h14;
	localparam logic [7:0] OP_XOR  = 8'h15;
	// Shift count is operand[2:0]
	localparam logic [7:0] OP_SHL  = 8'h16;
	localparam logic [7:0] OP_SHR  = 8'h17;
	localparam logic [7:0] OP_JMP  = 8'h20;
	localparam logic [7:0] OP_JZ   = 8'h21;
	localparam logic [7:0] OP_JC   = 8'h22;
	localparam logic [7:0] OP_IN   = 8'h30;
	localparam logic [7:0] OP_OUT  = 8'h31;
	localparam logic [7:0] OP_HALT = 8'h3f;

	// ALU functions
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_ADC = 3'd1;
	localparam alu_op_t ALU_SUB = 3'd2;
	localparam alu_op_t ALU_AND = 3'd3;
	localparam alu_op_t ALU_OR  = 3'd4;
	localparam alu_op_t ALU_XOR = 3'd5;
	localparam alu_op_t ALU_SHL = 3'd6;
	localparam alu_op_t ALU_SHR = 3'd7;

endpackage

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
	input  acc_proc_pkg::alu_op_t op,
	input  acc_proc_pkg::word_t   a,
	input  acc_proc_pkg::word_t   b,
	input  logic                  carry_in,
	output acc_proc_pkg::word_t   result,
	output acc_proc_pkg::flags_t  flags
);
	import acc_proc_pkg::*;

	// Ninth bit carries out or borrows
	logic [8:0] sum;
	// Extra bit catches the last bit shifted out
	logic [8:0] shl_wide;
	logic [8:0] shr_wide;

	assign shl_wide = {1'b0, a} << b[2:0];
	assign shr_wide = {a, 1'b0} >> b[2:0];

	always_comb begin
		sum           = '0;
		result        = '0;
		flags         = '0;
		case (op)
			ALU_ADD: begin
				sum           = {1'b0, a} + {1'b0, b};
				result        = sum[7:0];
				flags[FLAG_C] = sum[8];
				flags[FLAG_V] = (a[7] == b[7]) && (result[7] != a[7]);
			end
			ALU_ADC: begin
				sum           = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
				result        = sum[7:0];
				flags[FLAG_C] = sum[8];
				flags[FLAG_V] = (a[7] == b[7]) && (result[7] != a[7]);
			end
			ALU_SUB: begin
				// C is the borrow
				sum           = {1'b0, a} - {1'b0, b};
				result        = sum[7:0];
				flags[FLAG_C] = sum[8];
				flags[FLAG_V] = (a[7] != b[7]) && (result[7] != a[7]);
			end
			// Logic ops leave C and V clear
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SHL: begin
				result        = shl_wide[7:0];
				flags[FLAG_C] = shl_wide[8];
			end
			ALU_SHR: begin
				result        = shr_wide[8:1];
				flags[FLAG_C] = shr_wide[0];
			end
			default: result = '0;
		endcase
		flags[FLAG_Z] = (result == '0);
	end

endmodule

/* source/data_cache.sv */
`timescale 1ns/100ps

module data_cache (
	input  logic                g_clk,
	input  logic                arst_n,
	// Request held until done
	input  logic                req,
	input  logic                we,
	input  acc_proc_pkg::addr_t addr,
	input  acc_proc_pkg::word_t wdata,
	output logic                done,
	output acc_proc_pkg::word_t rdata
);
	import acc_proc_pkg::*;

	typedef enum logic {
		LOOKUP,
		FILL
	} cache_state_t;

	cache_state_t state;

	// Backing data RAM, cleared at start
	word_t ram [DMEM_DEPTH] = '{default: '0};

	// Lines, full address as tag
	addr_t                  tag_q  [CACHE_LINES];
	word_t                  data_q [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;
	// Age 0 is most recent, ages form a permutation
	logic [CACHE_IDX_W-1:0] age_q  [CACHE_LINES];

	logic                   hit;
	logic [CACHE_IDX_W-1:0] hit_idx;
	logic [CACHE_IDX_W-1:0] victim_idx;
	logic [CACHE_IDX_W-1:0] touch_idx;
	logic                   lookup;
	logic                   read_hit;
	logic                   read_miss;
	logic                   write_req;
	logic                   fill;
	logic                   touch_en;

	////////////////////
	// Tag match and victim
	////////////////////

	always_comb begin
		hit        = 1'b0;
		hit_idx    = '0;
		victim_idx = '0;
		for (int i = 0; i < CACHE_LINES; i++) begin
			if (valid_q[i] && tag_q[i] == addr) begin
				hit     = 1'b1;
				hit_idx = CACHE_IDX_W'(i);
			end
			// Oldest line; invalid lines are never the youngest
			if (age_q[i] == CACHE_IDX_W'(CACHE_LINES - 1)) begin
				victim_idx = CACHE_IDX_W'(i);
			end
		end
	end

	// New request only once the last done has gone
	assign lookup    = (state == LOOKUP) && req && !done;
	assign read_hit  = lookup && !we && hit;
	assign read_miss = lookup && !we && !hit;
	assign write_req = lookup && we;
	assign fill      = (state == FILL);
	assign touch_en  = read_hit || (write_req && hit) || fill;
	assign touch_idx = fill ? victim_idx : hit_idx;

	////////////////////
	// Control and LRU
	////////////////////

	always_ff @(posedge g_clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= LOOKUP;
			done    <= 1'b0;
			valid_q <= '0;
			for (int i = 0; i < CACHE_LINES; i++) begin
				age_q[i] <= CACHE_IDX_W'(i);
			end
		end else begin
			done <= 1'b0;
			case (state)
				LOOKUP: begin
					if (read_miss) begin
						state <= FILL;
					end else if (read_hit || write_req) begin
						done <= 1'b1;
					end
				end
				FILL: begin
					state               <= LOOKUP;
					done                <= 1'b1;
					valid_q[victim_idx] <= 1'b1;
				end
				default: state <= LOOKUP;
			endcase
			// Touched line becomes youngest, younger ones age by one
			if (touch_en) begin
				for (int i = 0; i < CACHE_LINES; i++) begin
					if (CACHE_IDX_W'(i) == touch_idx) begin
						age_q[i] <= '0;
					end else if (age_q[i] < age_q[touch_idx]) begin
						age_q[i] <= age_q[i] + 1'b1;
					end
				end
			end
		end
	end

	////////////////////
	// RAM and line data
	////////////////////

	always_ff @(posedge g_clk) begin
		// Write through, no allocate on a write miss
		if (write_req) begin
			ram[addr] <= wdata;
			if (hit) begin
				data_q[hit_idx] <= wdata;
			end
		end
		if (read_hit) begin
			rdata <= data_q[hit_idx];
		end
		if (fill) begin
			tag_q[victim_idx]  <= addr;
			data_q[victim_idx] <= ram[addr];
			rdata              <= ram[addr];
		end
	end

	// Done only answers a request from execute that is still up
	assert property (@(posedge g_clk) disable iff (!arst_n) done |-> req)
		else $error("cache done without pending req");

endmodule

/* source/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
	input  logic                   g_clk,
	input  logic                   arst_n,
	input  logic                   run,
	input  acc_proc_pkg::instr_t   instr,
	input  logic                   instr_valid,
	input  acc_proc_pkg::word_t    alu_result,
	input  acc_proc_pkg::flags_t   alu_flags,
	input  logic                   mem_done,
	input  acc_proc_pkg::word_t    mem_rdata,
	input  logic                   in_dev_hs,
	input  acc_proc_pkg::word_t    input_bus,
	input  logic                   out_dev_hs,
	input  logic                   out_dev_ack,
	output logic                   ex_busy,
	output logic                   redirect,
	output acc_proc_pkg::addr_t    redirect_addr,
	output acc_proc_pkg::alu_op_t  alu_op,
	output acc_proc_pkg::word_t    acc,
	output acc_proc_pkg::word_t    alu_operand,
	output logic                   carry_in,
	output logic                   mem_req,
	output logic                   mem_we,
	output acc_proc_pkg::addr_t    mem_addr,
	output acc_proc_pkg::word_t    mem_wdata,
	output logic                   in_dev_ack,
	output logic                   out_dev_req,
	output acc_proc_pkg::word_t    output_bus,
	output logic                   halted
);
	import acc_proc_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		EXEC,
		MEM_WAIT,
		IN_WAIT,
		IN_RELEASE,
		OUT_WAIT,
		OUT_RELEASE,
		HALT
	} ex_state_t;

	ex_state_t  state;
	flags_t     flags;
	logic [7:0] opcode;
	addr_t      operand;
	// Opcode of the memory instruction in progress
	logic [7:0] ex_op;
	logic [7:0] cur_op;
	logic       accept;

	assign opcode  = instr[15:8];
	assign operand = instr[7:0];
	assign accept  = (state == EXEC) && instr_valid;

	////////////////////
	// Decode
	////////////////////

	// Multi-cycle states hold off fetch
	assign ex_busy = (state == MEM_WAIT) || (state == IN_WAIT) || (state == IN_RELEASE) ||
		(state == OUT_WAIT) || (state == OUT_RELEASE);
	assign halted  = (state == HALT);

	// Jumps resolve on the flags as they stand
	assign redirect = accept && ((opcode == OP_JMP) || (opcode == OP_JZ && flags[FLAG_Z]) ||
		(opcode == OP_JC && flags[FLAG_C]));
	assign redirect_addr = operand;

	// Memory ops combine with the RAM byte, shifts with the operand
	assign cur_op      = (state == MEM_WAIT) ? ex_op : opcode;
	assign alu_operand = (state == MEM_WAIT) ? mem_rdata : operand;
	assign carry_in    = flags[FLAG_C];

	always_comb begin
		case (cur_op)
			OP_ADC:  alu_op = ALU_ADC;
			OP_SUB:  alu_op = ALU_SUB;
			OP_AND:  alu_op = ALU_AND;
			OP_OR:   alu_op = ALU_OR;
			OP_XOR:  alu_op = ALU_XOR;
			OP_SHL:  alu_op = ALU_SHL;
			OP_SHR:  alu_op = ALU_SHR;
			default: alu_op = ALU_ADD;
		endcase
	end

	////////////////////
	// Execute FSM
	////////////////////

	always_ff @(posedge g_clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= IDLE;
			acc         <= '0;
			flags       <= '0;
			mem_req     <= 1'b0;
			in_dev_ack  <= 1'b0;
			out_dev_req <= 1'b0;
		end else begin
			// Cache access always runs to done, even if run falls
			if (mem_req && mem_done) begin
				mem_req <= 1'b0;
			end
			if (!run) begin
				state       <= IDLE;
				acc         <= '0;
				flags       <= '0;
				in_dev_ack  <= 1'b0;
				out_dev_req <= 1'b0;
			end else begin
				case (state)
					IDLE: state <= EXEC;
					EXEC: begin
						if (instr_valid) begin
							case (opcode)
								OP_NOP: ;
								OP_LDI: acc <= operand;
								OP_LDM, OP_STM, OP_ADD, OP_ADC, OP_SUB,
								OP_AND, OP_OR, OP_XOR: begin
									mem_req <= 1'b1;
									state   <= MEM_WAIT;
								end
								OP_SHL, OP_SHR: begin
									acc   <= alu_result;
									flags <= alu_flags;
								end
								OP_IN:   state <= IN_WAIT;
								OP_OUT:  state <= OUT_WAIT;
								OP_HALT: state <= HALT;
								// Jumps handled by redirect, unknown acts as NOP
								default: ;
							endcase
						end
					end
					MEM_WAIT: begin
						if (mem_done) begin
							state <= EXEC;
							if (ex_op == OP_LDM) begin
								acc <= mem_rdata;
							end else if (ex_op != OP_STM) begin
								acc   <= alu_result;
								flags <= alu_flags;
							end
						end
					end
					// Input device four-phase handshake
					IN_WAIT: begin
						if (in_dev_hs) begin
							acc        <= input_bus;
							in_dev_ack <= 1'b1;
							state      <= IN_RELEASE;
						end
					end
					IN_RELEASE: begin
						if (!in_dev_hs) begin
							in_dev_ack <= 1'b0;
							state      <= EXEC;
						end
					end
					// Output device waits for ready first
					OUT_WAIT: begin
						if (out_dev_hs) begin
							out_dev_req <= 1'b1;
							state       <= OUT_RELEASE;
						end
					end
					OUT_RELEASE: begin
						// Drop req on ack, finish once ack is low again
						if (out_dev_ack) begin
							out_dev_req <= 1'b0;
						end else if (!out_dev_req) begin
							state <= EXEC;
						end
					end
					HALT: ;
					default: state <= IDLE;
				endcase
			end
		end
	end

	// Access details and output byte
	always_ff @(posedge g_clk) begin
		if (accept) begin
			ex_op     <= opcode;
			mem_addr  <= operand;
			mem_we    <= (opcode == OP_STM);
			mem_wdata <= acc;
		end
		if (state == OUT_WAIT && out_dev_hs) begin
			output_bus <= acc;
		end
	end

	// Devices are never served at once
	assert property (@(posedge g_clk) disable iff (!arst_n) !(out_dev_req && in_dev_ack))
		else $error("input ack and output req both high");

	// Cache sees a steady request until it answers
	assert property (@(posedge g_clk) disable iff (!arst_n)
		mem_req && !mem_done |=> mem_req && $stable(mem_addr) && $stable(mem_we) &&
		$stable(mem_wdata))
		else $error("mem request changed before mem_done");

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
	input  logic                   g_clk,
	input  logic                   arst_n,
	input  logic                   run,
	// Program load port, only while run is low
	input  logic                   prog_we,
	input  acc_proc_pkg::addr_t    prog_addr,
	input  acc_proc_pkg::instr_t   prog_data,
	// Control from the execute stage
	input  logic                   ex_busy,
	input  logic                   redirect,
	input  acc_proc_pkg::addr_t    redirect_addr,
	input  logic                   halted,
	output acc_proc_pkg::instr_t   instr,
	output logic                   instr_valid
);
	import acc_proc_pkg::*;

	// Instruction memory
	instr_t imem [IMEM_DEPTH];

	addr_t pc;
	logic  fetch_en;

	// Advance only while running and execute can take more
	assign fetch_en = run && !halted && !ex_busy && !redirect;

	////////////////////
	// PC and valid flag
	////////////////////

	always_ff @(posedge g_clk or negedge arst_n) begin
		if (!arst_n) begin
			pc          <= '0;
			instr_valid <= 1'b0;
		end else if (!run) begin
			// Stopped, restart from address 0
			pc          <= '0;
			instr_valid <= 1'b0;
		end else if (redirect) begin
			// Taken jump, drop the fetched instruction
			pc          <= redirect_addr;
			instr_valid <= 1'b0;
		end else if (fetch_en) begin
			pc          <= pc + 1'b1;
			instr_valid <= 1'b1;
		end
	end

	////////////////////
	// Memory and instruction register
	////////////////////

	always_ff @(posedge g_clk) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
		// Held on stall so the fetched word is kept
		if (fetch_en) begin
			instr <= imem[pc];
		end
	end

	// Loading must not overlap a running program
	assert property (@(posedge g_clk) disable iff (!arst_n) !(prog_we && run))
		else $error("prog_we asserted while run is high");

endmodule

/* tb/acc_proc_checker.sv */
`timescale 1ns/100ps

module acc_proc_checker (
	input logic                 g_clk,
	input logic                 arst_n,
	input logic                 run,
	input logic                 prog_we,
	input acc_proc_pkg::addr_t  prog_addr,
	input acc_proc_pkg::instr_t prog_data,
	input acc_proc_pkg::word_t  input_bus,
	input logic                 in_dev_ack,
	input logic                 out_dev_req,
	input logic                 out_dev_ack,
	input acc_proc_pkg::word_t  output_bus,
	input logic                 halted
);
	import acc_proc_pkg::*;

	// Upper bound on executed instructions per program
	localparam int MAX_STEPS = 512;

	string  test_name = "none";
	int     value_errors = 0;
	int     protocol_errors = 0;
	int     reset_errors = 0;
	int     programs_checked = 0;

	// Copy of the loaded program
	instr_t imem_img [IMEM_DEPTH];
	word_t  in_q [$];
	word_t  out_q [$];
	word_t  exp_q [$];
	logic   in_ack_q;
	logic   out_ack_q;
	logic   halted_q;

	////////////////////
	// ISA reference model
	////////////////////

	function automatic void run_model();
		logic [7:0] pc;
		logic [7:0] acc;
		logic [7:0] op;
		logic [7:0] opnd;
		logic [7:0] b;
		logic [8:0] wide;
		logic       c;
		logic       z;
		logic       done;
		int         steps;
		int         in_idx;
		logic [7:0] mem [DMEM_DEPTH];
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			mem[i] = 8'h00;
		end
		exp_q.delete();
		pc = 8'h00;
		acc = 8'h00;
		c = 1'b0;
		z = 1'b0;
		done = 1'b0;
		steps = 0;
		in_idx = 0;
		while (!done) begin
			op = imem_img[pc][15:8];
			opnd = imem_img[pc][7:0];
			pc = pc + 8'd1;
			steps++;
			b = mem[opnd];
			case (op)
				OP_LDI: acc = opnd;
				OP_LDM: acc = b;
				OP_STM: mem[opnd] = acc;
				OP_ADD, OP_ADC: begin
					// Carry in only for ADC, taken before C changes
					wide = {1'b0, acc} + {1'b0, b} + ((op == OP_ADC) ? {8'd0, c} : 9'd0);
					c = wide[8];
					acc = wide[7:0];
					z = (acc == 8'h00);
				end
				OP_SUB: begin
					wide = {1'b0, acc} - {1'b0, b};
					c = wide[8];
					acc = wide[7:0];
					z = (acc == 8'h00);
				end
				OP_AND, OP_OR, OP_XOR: begin
					if (op == OP_AND) acc = acc & b;
					else if (op == OP_OR) acc = acc | b;
					else acc = acc ^ b;
					c = 1'b0;
					z = (acc == 8'h00);
				end
				OP_SHL, OP_SHR: begin
					// One bit at a time, C keeps the last bit out
					c = 1'b0;
					for (int k = 0; k < int'(opnd[2:0]); k++) begin
						if (op == OP_SHL) begin
							c = acc[7];
							acc = {acc[6:0], 1'b0};
						end else begin
							c = acc[0];
							acc = {1'b0, acc[7:1]};
						end
					end
					z = (acc == 8'h00);
				end
				OP_JMP: pc = opnd;
				OP_JZ:  if (z) pc = opnd;
				OP_JC:  if (c) pc = opnd;
				OP_IN: begin
					if (in_idx < in_q.size()) begin
						acc = in_q[in_idx];
						in_idx++;
					end else begin
						protocol_errors++;
						$display("%s: program executed IN but no input byte was accepted",
							test_name);
					end
				end
				OP_OUT:  exp_q.push_back(acc);
				OP_HALT: done = 1'b1;
				default: ;
			endcase
			if (!done && steps >= MAX_STEPS) begin
				protocol_errors++;
				$display("%s: reference model ran too long without HALT", test_name);
				done = 1'b1;
			end
		end
		if (in_idx != in_q.size()) begin
			protocol_errors++;
			$display("%s: DUT accepted %0d input bytes, program reads %0d",
				test_name, in_q.size(), in_idx);
		end
	endfunction

	task automatic compare_outputs();
		run_model();
		for (int i = 0; i < exp_q.size(); i++) begin
			if (i >= out_q.size()) begin
				value_errors++;
				$display("Fail %s: output %0d expected %02h actual none", test_name, i,
					exp_q[i]);
			end else if (out_q[i] !== exp_q[i]) begin
				value_errors++;
				$display("Fail %s: output %0d expected %02h actual %02h", test_name, i,
					exp_q[i], out_q[i]);
			end
		end
		if (out_q.size() > exp_q.size()) begin
			protocol_errors++;
			$display("%s: %0d extra output bytes", test_name, out_q.size() - exp_q.size());
		end
		programs_checked++;
	endtask

	////////////////////
	// Capture and compare
	////////////////////

	always @(posedge g_clk or negedge arst_n) begin
		if (!arst_n) begin
			in_q.delete();
			out_q.delete();
			in_ack_q <= 1'b0;
			out_ack_q <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			in_ack_q <= in_dev_ack;
			out_ack_q <= out_dev_ack;
			halted_q <= halted;
			if (prog_we) begin
				imem_img[prog_addr] = prog_data;
			end
			if (!run) begin
				in_q.delete();
				out_q.delete();
			end else begin
				// Byte taken on the rising ack
				if (in_dev_ack && !in_ack_q) begin
					in_q.push_back(input_bus);
				end
				if (out_dev_ack && !out_ack_q) begin
					if (halted) begin
						protocol_errors++;
						$display("%s: output byte seen after halted", test_name);
					end
					out_q.push_back(output_bus);
				end
				if (halted && !halted_q) begin
					compare_outputs();
				end
			end
		end
	end

	// Outputs held low through reset
	always @(posedge g_clk) begin
		if (!arst_n && (in_dev_ack || out_dev_req || halted)) begin
			reset_errors++;
			$display("%s: handshake outputs or halted not low during reset", test_name);
		end
	end

endmodule

/* tb/acc_proc_tb.sv */
`timescale 1ns/100ps

module acc_proc_tb;
	import acc_proc_pkg::*;

	localparam int SEED = 2060;
	localparam int MAX_DELAY = 16;
	// Seven runs counting the aborted one
	localparam int NUM_RUNS = 7;
	localparam int MAX_INSTR = 256;
	localparam int CYCLES_PER_INSTR = 4 * (MAX_DELAY + 2) + 8;
	localparam int WATCHDOG_NS = NUM_RUNS * MAX_INSTR * CYCLES_PER_INSTR * 4;

	logic   g_clk;
	logic   arst_n;
	logic   run;
	logic   prog_we;
	addr_t  prog_addr;
	instr_t prog_data;
	logic   in_dev_hs;
	word_t  input_bus;
	logic   out_dev_hs;
	logic   out_dev_ack;
	logic   in_dev_ack;
	logic   out_dev_req;
	word_t  output_bus;
	logic   halted;

	int     max_delay = 0;
	int     expected_checks = 0;
	int     total_errors;
	instr_t prog [$];

	acc_proc uut (.*);

	acc_proc_checker chk (
		.g_clk, .arst_n, .run, .prog_we, .prog_addr, .prog_data,
		.input_bus, .in_dev_ack, .out_dev_req, .out_dev_ack, .output_bus, .halted
	);

	initial begin
		g_clk = 1'b0;
		forever #2 g_clk = ~g_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, a program never reached HALT");
		$display("Test FAILED");
		$finish;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge g_clk);
	endtask

	function automatic int rand_delay();
		return int'($urandom_range(max_delay, 0));
	endfunction

	////////////////////
	// Device models
	////////////////////

	initial begin
		in_dev_hs = 1'b0;
		input_bus = 8'h00;
		@(posedge arst_n);
		forever begin
			@(negedge g_clk);
			wait_cycles(rand_delay());
			// Bus held until the next byte
			input_bus = 8'($urandom);
			in_dev_hs = 1'b1;
			while (!in_dev_ack) @(negedge g_clk);
			wait_cycles(rand_delay());
			in_dev_hs = 1'b0;
			while (in_dev_ack) @(negedge g_clk);
		end
	end

	initial begin
		out_dev_hs = 1'b0;
		out_dev_ack = 1'b0;
		@(posedge arst_n);
		forever begin
			@(negedge g_clk);
			wait_cycles(rand_delay());
			out_dev_hs = 1'b1;
			while (!out_dev_req) @(negedge g_clk);
			wait_cycles(rand_delay());
			out_dev_ack = 1'b1;
			@(negedge g_clk);
			while (out_dev_req) @(negedge g_clk);
			wait_cycles(rand_delay());
			out_dev_ack = 1'b0;
			out_dev_hs = 1'b0;
		end
	end

	////////////////////
	// Program helpers
	////////////////////

	task automatic emit(input logic [7:0] op, input logic [7:0] opnd);
		prog.push_back({op, opnd});
	endtask

	task automatic start_program(input string name);
		for (int i = 0; i < prog.size(); i++) begin
			@(negedge g_clk);
			prog_we = 1'b1;
			prog_addr = 8'(i);
			prog_data = prog[i];
		end
		@(negedge g_clk);
		prog_we = 1'b0;
		chk.test_name = name;
		@(negedge g_clk);
		run = 1'b1;
	endtask

	task automatic finish_program();
		while (!halted) @(negedge g_clk);
		wait_cycles(2);
		run = 1'b0;
		expected_checks++;
		wait_cycles(2);
		prog.delete();
	endtask

	// Operation, then a three-way branch on Z and C
	task automatic branch_block(input word_t x, input word_t y, input logic [7:0] op,
		input logic [7:0] opnd);
		int p;
		p = prog.size();
		emit(OP_LDI, x);
		emit(OP_STM, 8'h20);
		emit(OP_LDI, y);
		emit(OP_STM, 8'h21);
		emit(OP_LDM, 8'h20);
		emit(op, opnd);
		emit(OP_JZ, 8'(p + 12));
		emit(OP_JC, 8'(p + 15));
		emit(OP_LDI, 8'h55);
		emit(OP_OUT, 8'h00);
		emit(OP_JMP, 8'(p + 17));
		emit(OP_NOP, 8'h00);
		emit(OP_LDI, 8'haa);
		emit(OP_OUT, 8'h00);
		emit(OP_JMP, 8'(p + 17));
		emit(OP_LDI, 8'hcc);
		emit(OP_OUT, 8'h00);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		void'($urandom(SEED));
		arst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		repeat (3) @(posedge g_clk);
		@(negedge g_clk);
		arst_n = 1'b1;

		// Arithmetic and logic
		max_delay = 4;
		for (int r = 0; r < 4; r++) begin
			emit(OP_LDI, 8'($urandom));
			emit(OP_STM, 8'h10);
			emit(OP_LDI, 8'($urandom));
			emit(OP_STM, 8'h11);
			emit(OP_LDM, 8'h10);
			emit(OP_ADD, 8'h11);
			emit(OP_OUT, 8'h00);
			emit(OP_ADC, 8'h11);
			emit(OP_OUT, 8'h00);
			for (int k = 0; k < 4; k++) begin
				emit(OP_LDM, 8'h10);
				emit(OP_SUB + 8'(k), 8'h11);
				emit(OP_OUT, 8'h00);
			end
			emit(OP_LDM, 8'h10);
			emit(OP_SHL, 8'($urandom_range(7, 0)));
			emit(OP_OUT, 8'h00);
			emit(OP_SHR, 8'($urandom_range(7, 0)));
			emit(OP_OUT, 8'h00);
		end
		emit(OP_HALT, 8'h00);
		start_program("alu_ops");
		finish_program();

		// Flags and branches, forced zero, carry and borrow cases
		branch_block(8'h05, 8'h05, OP_SUB, 8'h21);
		branch_block(8'hf0, 8'h20, OP_ADD, 8'h21);
		branch_block(8'h03, 8'h09, OP_SUB, 8'h21);
		branch_block(8'h80, 8'h00, OP_SHL, 8'h01);
		branch_block(8'h41, 8'h00, OP_SHR, 8'h01);
		branch_block(8'h12, 8'h34, OP_ADD, 8'h21);
		branch_block(8'($urandom), 8'($urandom), OP_SUB, 8'h21);
		emit(OP_HALT, 8'h00);
		start_program("branches");
		finish_program();

		// Cache, eight addresses over four lines
		for (int i = 0; i < 8; i++) begin
			emit(OP_LDI, 8'($urandom));
			emit(OP_STM, 8'(8'h40 + i * 5));
		end
		for (int i = 0; i < 8; i++) begin
			emit(OP_LDM, 8'(8'h40 + i * 5));
			emit(OP_OUT, 8'h00);
		end
		for (int i = 7; i >= 0; i--) begin
			emit(OP_LDM, 8'(8'h40 + i * 5));
			emit(OP_OUT, 8'h00);
		end
		// Write to a resident line, then to an evicted one
		emit(OP_LDI, 8'($urandom));
		emit(OP_STM, 8'h40);
		emit(OP_LDM, 8'h40);
		emit(OP_OUT, 8'h00);
		emit(OP_LDI, 8'($urandom));
		emit(OP_STM, 8'h63);
		emit(OP_LDM, 8'h63);
		emit(OP_OUT, 8'h00);
		emit(OP_HALT, 8'h00);
		start_program("cache");
		finish_program();

		// Input echo
		max_delay = 8;
		for (int i = 0; i < 10; i++) begin
			emit(OP_IN, 8'h00);
			emit(OP_OUT, 8'h00);
		end
		emit(OP_HALT, 8'h00);
		start_program("input_echo");
		finish_program();

		// Output back-pressure
		max_delay = MAX_DELAY;
		for (int i = 0; i < 6; i++) begin
			emit(OP_IN, 8'h00);
			emit(OP_OUT, 8'h00);
			emit(OP_LDI, 8'($urandom));
			emit(OP_OUT, 8'h00);
		end
		emit(OP_HALT, 8'h00);
		start_program("back_pressure");
		finish_program();

		// Reset mid-program, then rerun
		max_delay = 10;
		emit(OP_LDI, 8'($urandom));
		emit(OP_STM, 8'h30);
		for (int i = 0; i < 20; i++) begin
			emit(OP_IN, 8'h00);
			emit(OP_ADD, 8'h30);
			emit(OP_OUT, 8'h00);
		end
		emit(OP_HALT, 8'h00);
		start_program("reset_rerun");
		wait_cycles(40);
		arst_n = 1'b0;
		run = 1'b0;
		wait_cycles(3);
		arst_n = 1'b1;
		@(negedge g_clk);
		run = 1'b1;
		finish_program();

		total_errors = chk.value_errors + chk.protocol_errors + chk.reset_errors;
		$display("Errors: value %0d, protocol %0d, reset %0d; programs checked %0d of %0d",
			chk.value_errors, chk.protocol_errors, chk.reset_errors,
			chk.programs_checked, expected_checks);
		if (total_errors == 0 && chk.programs_checked == expected_checks) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
